// ==== verilog/dma_types_pkg.sv ====
/* DMA descriptor, register and FIFO beat types. Lengths count 32-bit beats and must be
   at least 1; a single descriptor is held at a time. */
`default_nettype none

package dma_types_pkg;

   localparam int DATA_W      = 32;
   localparam int LENGTH_W    = 16;
   localparam int ADDR_W      = 32;
   localparam int FIFO_DEPTH  = 32;
   localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
   localparam int WR_STATES_W = 9;
   localparam int CSR_ADDR_W  = 3;
   localparam int CSR_DATA_W  = 32;

   // cycles between a burst's last beat and the next AW
   localparam int ADDR_PROP_CYCLES = 3;

   localparam logic [CSR_ADDR_W-1:0] REG_DEST_ADDR = 3'd0;
   localparam logic [CSR_ADDR_W-1:0] REG_LENGTH    = 3'd1;
   localparam logic [CSR_ADDR_W-1:0] REG_CONTROL   = 3'd2;
   localparam logic [CSR_ADDR_W-1:0] REG_STATUS    = 3'd3;
   localparam logic [CSR_ADDR_W-1:0] REG_CLK_CNT   = 3'd4;
   localparam logic [CSR_ADDR_W-1:0] REG_VALID_CNT = 3'd5;

   typedef enum logic [1:0] {
      stand_by,
      host_to_ddr,
      ddr_to_host,
      ddr_to_ddr
   } t_mode;

   typedef struct packed {
      logic [ADDR_W-1:0]   dest_addr;
      logic [LENGTH_W-1:0] length;
      t_mode               mode;
   } t_descriptor;

   // field order matches the control register bits
   typedef struct packed {
      t_mode mode;
      logic  reset_dispatcher;
      logic  go;
   } t_control;

   typedef struct packed {
      logic                   busy;
      logic                   stopped_on_error;
      logic                   wr_rsp_err;
      logic [WR_STATES_W-1:0] wr_state;
   } t_status;

   typedef struct packed {
      logic [LENGTH_W-1:0] clk_cnt;
      logic [LENGTH_W-1:0] valid_cnt;
   } t_perf;

   typedef struct packed {
      logic              packet_complete;
      logic              burst_last;
      logic [DATA_W-1:0] data;
   } t_beat;

endpackage

`default_nettype wire

// ==== verilog/axi_wr_pkg.sv ====
/* AXI write-channel types for a 32-bit data bus. Only full-word strobes are used. */
`default_nettype none

package axi_wr_pkg;

   localparam int AXI_ADDR_W     = 32;
   localparam int AXI_DATA_W     = 32;
   localparam int AXI_LEN_W      = 4;
   localparam int BYTES_PER_BEAT = AXI_DATA_W / 8;

   // bytes covered by one full burst
   localparam int BURST_BYTES = BYTES_PER_BEAT << AXI_LEN_W;

   localparam logic [2:0] AXI_SIZE = 3'($clog2(BYTES_PER_BEAT));

   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } t_burst;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } t_resp;

   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_LEN_W-1:0]  len;
      logic [2:0]            size;
      t_burst                burst;
   } t_aw;

   typedef struct packed {
      logic [AXI_DATA_W-1:0]     data;
      logic [BYTES_PER_BEAT-1:0] strb;
      logic                      last;
   } t_w;

   typedef struct packed {
      t_resp resp;
   } t_b;

endpackage

`default_nettype wire

// ==== verilog/dma_wr_csr.sv ====
/* Register block. Go and reset_dispatcher are self-clearing; read data follows a read
   strobe by one cycle. The descriptor must not be rewritten while desc_pending is set. */
`timescale 1ns/1ns
`default_nettype none

module dma_wr_csr (
   input  logic                                   clk,
   input  logic                                   reset_n,
   input  logic                                   csr_wr,
   input  logic                                   csr_rd,
   input  logic [dma_types_pkg::CSR_ADDR_W-1:0]   csr_addr,
   input  logic [dma_types_pkg::CSR_DATA_W-1:0]   csr_wdata,
   output logic [dma_types_pkg::CSR_DATA_W-1:0]   csr_rdata,
   output logic                                   csr_rvalid,
   output dma_types_pkg::t_descriptor             descriptor,
   output logic                                   desc_pending,
   input  logic                                   desc_taken,
   output logic                                   reset_dispatcher,
   input  dma_types_pkg::t_status                 status,
   input  dma_types_pkg::t_perf                   perf
);

   dma_types_pkg::t_control ctrl;
   dma_types_pkg::t_control rd_ctrl;
   logic                    ctrl_wr;

   assign ctrl    = dma_types_pkg::t_control'(csr_wdata[$bits(dma_types_pkg::t_control)-1:0]);
   assign ctrl_wr = csr_wr & (csr_addr == dma_types_pkg::REG_CONTROL);

   // pulse bits always read back as zero
   assign rd_ctrl = '{mode: descriptor.mode, reset_dispatcher: 1'b0, go: 1'b0};

   always_ff @(posedge clk) begin
      if (csr_wr) begin
         case (csr_addr)
            dma_types_pkg::REG_DEST_ADDR: descriptor.dest_addr <= csr_wdata;
            dma_types_pkg::REG_LENGTH:
               descriptor.length <= csr_wdata[dma_types_pkg::LENGTH_W-1:0];
            dma_types_pkg::REG_CONTROL:   descriptor.mode <= ctrl.mode;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         desc_pending     <= 1'b0;
         reset_dispatcher <= 1'b0;
      end else begin
         reset_dispatcher <= ctrl_wr & ctrl.reset_dispatcher;
         if (ctrl_wr & ctrl.go) begin
            desc_pending <= 1'b1;
         end else if (desc_taken) begin
            desc_pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         csr_rvalid <= 1'b0;
      end else begin
         csr_rvalid <= csr_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (csr_rd) begin
         case (csr_addr)
            dma_types_pkg::REG_DEST_ADDR: csr_rdata <= descriptor.dest_addr;
            dma_types_pkg::REG_LENGTH:    csr_rdata <= 32'(descriptor.length);
            dma_types_pkg::REG_CONTROL:   csr_rdata <= 32'(rd_ctrl);
            dma_types_pkg::REG_STATUS:    csr_rdata <= 32'(status);
            dma_types_pkg::REG_CLK_CNT:   csr_rdata <= 32'(perf.clk_cnt);
            dma_types_pkg::REG_VALID_CNT: csr_rdata <= 32'(perf.valid_cnt);
            default:                      csr_rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/data_fifo.sv ====
/* Show-ahead beat FIFO. No full flag: the source must never push into a full FIFO. */
`timescale 1ns/1ns
`default_nettype none

module data_fifo (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 beat_push,
   input  dma_types_pkg::t_beat push_data,
   input  logic                 rd_en,
   output dma_types_pkg::t_beat rd_data,
   output logic                 not_empty
);

   dma_types_pkg::t_beat                  mem [dma_types_pkg::FIFO_DEPTH];
   logic [dma_types_pkg::FIFO_PTR_W-1:0]  wr_ptr;
   logic [dma_types_pkg::FIFO_PTR_W-1:0]  rd_ptr;
   logic [dma_types_pkg::FIFO_PTR_W:0]    count;
   logic                                  pop;

   // a pop on an empty FIFO is ignored
   assign pop       = rd_en & not_empty;
   assign not_empty = (count != '0);
   assign rd_data   = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (beat_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (beat_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({beat_push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/write_dest_fsm.sv ====
/* AXI write master for one descriptor. Beats must carry burst_last on every 16th beat and
   on the final one; packet_complete is carried but the end follows the descriptor length. */
`timescale 1ns/1ns
`default_nettype none

module write_dest_fsm (
   input  logic                        clk,
   input  logic                        reset_n,
   input  dma_types_pkg::t_descriptor  descriptor,
   input  logic                        desc_pending,
   output logic                        desc_taken,
   input  logic                        reset_dispatcher,
   input  dma_types_pkg::t_beat        rd_data,
   input  logic                        not_empty,
   output logic                        rd_en,
   output logic                        awvalid,
   output axi_wr_pkg::t_aw             aw,
   input  logic                        awready,
   output logic                        wvalid,
   output axi_wr_pkg::t_w              w,
   input  logic                        wready,
   input  logic                        bvalid,
   input  axi_wr_pkg::t_b              b,
   output logic                        bready,
   output dma_types_pkg::t_status      status,
   output dma_types_pkg::t_perf        perf,
   output logic                        wr_done
);

   // one-hot
   typedef enum logic [dma_types_pkg::WR_STATES_W-1:0] {
      idle                 = 9'h001,
      addr_prop_delay      = 9'h002,
      addr_setup           = 9'h004,
      fifo_empty           = 9'h008,
      not_ready            = 9'h010,
      fifo_empty_not_ready = 9'h020,
      rd_fifo_wr_dest      = 9'h040,
      wait_for_wr_rsp      = 9'h080,
      error                = 9'h100
   } t_state;

   t_state state;
   t_state next;

   logic [dma_types_pkg::LENGTH_W-1:0]                  len_m1;
   logic [dma_types_pkg::LENGTH_W-axi_wr_pkg::AXI_LEN_W:0] num_bursts;
   logic [dma_types_pkg::LENGTH_W-axi_wr_pkg::AXI_LEN_W:0] bursts_sent;
   logic [dma_types_pkg::LENGTH_W-axi_wr_pkg::AXI_LEN_W:0] rsp_cnt;
   logic [dma_types_pkg::LENGTH_W-axi_wr_pkg::AXI_LEN_W:0] rsp_cnt_next;
   logic [axi_wr_pkg::AXI_LEN_W-1:0]                    last_len;
   axi_wr_pkg::t_burst                                  burst_code;
   logic [dma_types_pkg::ADDR_W-1:0]                    burst_addr;
   logic [1:0]                                          delay_cnt;
   logic rsp_err;
   logic start;
   logic in_w;
   logic aw_hs;
   logic w_hs;
   logic w_last_done;
   logic b_hs;
   logic err_now;
   logic err_any;
   logic all_rsp;
   logic load_w;

   assign len_m1      = descriptor.length - 1'b1;
   assign start       = (state == idle) & desc_pending & not_empty;
   assign desc_taken  = start;
   assign in_w        = state inside {rd_fifo_wr_dest, fifo_empty, not_ready,
                                      fifo_empty_not_ready};
   assign aw_hs       = awvalid & awready;
   assign w_hs        = wvalid & wready;
   assign w_last_done = w_hs & w.last;
   assign b_hs        = bvalid & bready;
   assign err_now     = b_hs & status.busy & (b.resp != axi_wr_pkg::OKAY);
   assign err_any     = rsp_err | err_now;
   assign rsp_cnt_next = rsp_cnt + b_hs;
   assign all_rsp     = (rsp_cnt_next == num_bursts);

   // refill W once the current word goes, but never past the burst's last beat
   assign load_w = in_w & not_empty & !(wvalid & w.last) & (!wvalid | wready);
   assign rd_en  = load_w;

   assign awvalid  = (state == addr_setup);
   assign bready   = 1'b1;
   assign aw.addr  = burst_addr;
   assign aw.len   = (bursts_sent == num_bursts - 1'b1) ? last_len : '1;
   assign aw.size  = axi_wr_pkg::AXI_SIZE;
   assign aw.burst = burst_code;

   assign status.busy             = !(state inside {idle, error});
   assign status.stopped_on_error = (state == error);
   assign status.wr_rsp_err       = rsp_err;
   assign status.wr_state         = state;

   always_comb begin
      next = state;
      unique case (state)
         idle: begin
            if (start) next = addr_setup;
         end
         addr_setup: begin
            if (aw_hs) next = rd_fifo_wr_dest;
         end
         rd_fifo_wr_dest, fifo_empty, not_ready, fifo_empty_not_ready: begin
            if (w_last_done) begin
               if (err_any) next = error;
               else if (bursts_sent != num_bursts) next = addr_prop_delay;
               else next = wait_for_wr_rsp;
            end else if (load_w) begin
               next = rd_fifo_wr_dest;
            end else if (wvalid & !wready) begin
               next = not_empty ? not_ready : fifo_empty_not_ready;
            end else begin
               next = fifo_empty;
            end
         end
         addr_prop_delay: begin
            if (err_any) next = error;
            else if (delay_cnt == 2'(dma_types_pkg::ADDR_PROP_CYCLES - 1)) next = addr_setup;
         end
         wait_for_wr_rsp: begin
            if (err_any) next = error;
            else if (all_rsp) next = idle;
         end
         error: begin
            if (reset_dispatcher) next = idle;
         end
         default: next = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state       <= idle;
         wvalid      <= 1'b0;
         wr_done     <= 1'b0;
         rsp_err     <= 1'b0;
         delay_cnt   <= '0;
         bursts_sent <= '0;
         rsp_cnt     <= '0;
      end else begin
         state     <= next;
         wr_done   <= (state == wait_for_wr_rsp) & all_rsp & !err_any;
         delay_cnt <= (state == addr_prop_delay) ? delay_cnt + 1'b1 : '0;
         if (load_w) begin
            wvalid <= 1'b1;
         end else if (wready) begin
            wvalid <= 1'b0;
         end
         if (start) begin
            bursts_sent <= '0;
            rsp_cnt     <= '0;
            rsp_err     <= 1'b0;
         end else begin
            bursts_sent <= bursts_sent + aw_hs;
            if (status.busy) rsp_cnt <= rsp_cnt_next;
            if (err_now) begin
               rsp_err <= 1'b1;
            end else if (reset_dispatcher) begin
               rsp_err <= 1'b0;
            end
         end
      end
   end

   // descriptor is latched on leaving idle, it may change afterwards
   always_ff @(posedge clk) begin
      if (start) begin
         burst_addr <= descriptor.dest_addr;
         num_bursts <= {1'b0, len_m1[dma_types_pkg::LENGTH_W-1:axi_wr_pkg::AXI_LEN_W]} + 1'b1;
         last_len   <= len_m1[axi_wr_pkg::AXI_LEN_W-1:0];
         burst_code <= (descriptor.mode == dma_types_pkg::ddr_to_host) ?
                       axi_wr_pkg::BURST_WRAP : axi_wr_pkg::BURST_INCR;
      end else if (aw_hs) begin
         burst_addr <= burst_addr + axi_wr_pkg::BURST_BYTES;
      end
      if (load_w) begin
         w.data <= rd_data.data;
         w.last <= rd_data.burst_last;
         w.strb <= '1;
      end
   end

   // bandwidth counters, held after the transfer for readback
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         perf <= '0;
      end else if (start) begin
         perf <= '0;
      end else begin
         if (status.busy) perf.clk_cnt <= perf.clk_cnt + 1'b1;
         if (w_hs) perf.valid_cnt <= perf.valid_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/dma_wr_top.sv ====
/* DMA write side. The upstream read engine pushes beats directly; there is no
   back-pressure on beat_push. */
`timescale 1ns/1ns
`default_nettype none

module dma_wr_top (
   input  logic                                 clk,
   input  logic                                 reset_n,
   input  logic                                 csr_wr,
   input  logic                                 csr_rd,
   input  logic [dma_types_pkg::CSR_ADDR_W-1:0] csr_addr,
   input  logic [dma_types_pkg::CSR_DATA_W-1:0] csr_wdata,
   output logic [dma_types_pkg::CSR_DATA_W-1:0] csr_rdata,
   output logic                                 csr_rvalid,
   input  logic                                 beat_push,
   input  dma_types_pkg::t_beat                 push_data,
   output logic                                 awvalid,
   output axi_wr_pkg::t_aw                      aw,
   input  logic                                 awready,
   output logic                                 wvalid,
   output axi_wr_pkg::t_w                       w,
   input  logic                                 wready,
   input  logic                                 bvalid,
   input  axi_wr_pkg::t_b                       b,
   output logic                                 bready,
   output logic                                 wr_done
);

   dma_types_pkg::t_descriptor descriptor;
   dma_types_pkg::t_status     status;
   dma_types_pkg::t_perf       perf;
   dma_types_pkg::t_beat       rd_data;
   logic                       desc_pending;
   logic                       desc_taken;
   logic                       reset_dispatcher;
   logic                       not_empty;
   logic                       rd_en;

   dma_wr_csr csr0 (
      .clk              (clk),
      .reset_n          (reset_n),
      .csr_wr           (csr_wr),
      .csr_rd           (csr_rd),
      .csr_addr         (csr_addr),
      .csr_wdata        (csr_wdata),
      .csr_rdata        (csr_rdata),
      .csr_rvalid       (csr_rvalid),
      .descriptor       (descriptor),
      .desc_pending     (desc_pending),
      .desc_taken       (desc_taken),
      .reset_dispatcher (reset_dispatcher),
      .status           (status),
      .perf             (perf)
   );

   data_fifo fifo0 (
      .clk       (clk),
      .reset_n   (reset_n),
      .beat_push (beat_push),
      .push_data (push_data),
      .rd_en     (rd_en),
      .rd_data   (rd_data),
      .not_empty (not_empty)
   );

   write_dest_fsm fsm0 (
      .clk              (clk),
      .reset_n          (reset_n),
      .descriptor       (descriptor),
      .desc_pending     (desc_pending),
      .desc_taken       (desc_taken),
      .reset_dispatcher (reset_dispatcher),
      .rd_data          (rd_data),
      .not_empty        (not_empty),
      .rd_en            (rd_en),
      .awvalid          (awvalid),
      .aw               (aw),
      .awready          (awready),
      .wvalid           (wvalid),
      .w                (w),
      .wready           (wready),
      .bvalid           (bvalid),
      .b                (b),
      .bready           (bready),
      .status           (status),
      .perf             (perf),
      .wr_done          (wr_done)
   );

endmodule

`default_nettype wire

// ==== tests/tb_dma_wr.sv ====
/* Testbench for the DMA write side with a randomly stalling AXI slave. The slave accepts
   any address and keeps no memory image; beats are checked in order. */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_wr;

   localparam int MAX_CYCLES = 4000;
   // how far the source may run ahead of the W channel
   localparam int AHEAD_LIMIT = 16;

   logic                                 clk;
   logic                                 reset_n;
   logic                                 csr_wr;
   logic                                 csr_rd;
   logic [dma_types_pkg::CSR_ADDR_W-1:0] csr_addr;
   logic [dma_types_pkg::CSR_DATA_W-1:0] csr_wdata;
   logic [dma_types_pkg::CSR_DATA_W-1:0] csr_rdata;
   logic                                 csr_rvalid;
   logic                                 beat_push;
   dma_types_pkg::t_beat                 push_data;
   logic                                 awvalid;
   axi_wr_pkg::t_aw                      aw;
   logic                                 awready = 1'b0;
   logic                                 wvalid;
   axi_wr_pkg::t_w                       w;
   logic                                 wready = 1'b0;
   logic                                 bvalid = 1'b0;
   axi_wr_pkg::t_b                       b = '0;
   logic                                 bready;
   logic                                 wr_done;

   // scoreboard
   axi_wr_pkg::t_aw exp_aw_q[$];
   logic [31:0]     exp_data_q[$];
   logic            exp_last_q[$];
   logic [31:0]     rx_data_q[$];
   axi_wr_pkg::t_aw exp_aw = '0;
   logic [31:0]     exp_data = '0;
   logic            exp_last = 1'b0;
   logic            aw_expected = 1'b0;
   logic            w_expected = 1'b0;
   axi_wr_pkg::t_aw aw_prev = '0;
   axi_wr_pkg::t_w  w_prev = '0;

   axi_wr_pkg::t_resp resp_code;
   logic              stall_en;
   logic              expect_err;
   int                b_pending = 0;
   int                aw_seen = 0;
   int                bursts_done = 0;
   int                beats_accepted = 0;
   int                beats_pushed = 0;
   int                done_count = 0;
   int                cycles = 0;
   int                check_errors = 0;
   int                protocol_errors = 0;

   dma_wr_top dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // AXI slave model and scoreboard bookkeeping
   always @(posedge clk) begin
      int pend;
      if (!reset_n) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         if (awvalid && awready) begin
            if (exp_aw_q.size() > 0) exp_aw_q.delete(0);
            aw_seen <= aw_seen + 1;
         end
         if (wvalid && wready) begin
            rx_data_q.push_back(w.data);
            if (exp_data_q.size() > 0) begin
               exp_data_q.delete(0);
               exp_last_q.delete(0);
            end
            beats_accepted <= beats_accepted + 1;
            if (w.last) bursts_done <= bursts_done + 1;
         end
         if (wr_done) done_count <= done_count + 1;
         // one B per burst after its last beat
         pend = b_pending;
         if (wvalid && wready && w.last) pend = pend + 1;
         if (bvalid && bready) pend = pend - 1;
         b_pending <= pend;
         bvalid    <= (pend > 0);
         b.resp    <= resp_code;
         awready   <= stall_en ? ($urandom_range(3, 0) != 0) : 1'b1;
         wready    <= stall_en ? ($urandom_range(3, 0) != 0) : 1'b1;
         aw_expected <= (exp_aw_q.size() > 0);
         w_expected  <= (exp_data_q.size() > 0);
         if (exp_aw_q.size() > 0) exp_aw <= exp_aw_q[0];
         if (exp_data_q.size() > 0) begin
            exp_data <= exp_data_q[0];
            exp_last <= exp_last_q[0];
         end
      end
      aw_prev <= aw;
      w_prev  <= w;
   end

   task automatic report_bus(input string text);
      protocol_errors++;
      $display("%s", text);
   endtask

   assert property (@(posedge clk) !reset_n |=> !awvalid && !wvalid && !wr_done && !csr_rvalid)
      else report_bus($sformatf("at %0t outputs not idle after reset", $time));

   assert property (@(posedge clk) disable iff (!reset_n) bready)
      else report_bus($sformatf("** Error at %0t: bready expected 1, got %b",
                                $time, $sampled(bready)));

   assert property (@(posedge clk) disable iff (!reset_n) awvalid && !awready |=> awvalid)
      else report_bus($sformatf("at %0t awvalid dropped before awready", $time));

   assert property (@(posedge clk) disable iff (!reset_n)
         awvalid && !awready |=> aw == aw_prev)
      else report_bus($sformatf("** Error at %0t: aw expected %h, got %h",
                                $time, $sampled(aw_prev), $sampled(aw)));

   assert property (@(posedge clk) disable iff (!reset_n) wvalid && !wready |=> wvalid)
      else report_bus($sformatf("at %0t wvalid dropped before wready", $time));

   assert property (@(posedge clk) disable iff (!reset_n)
         wvalid && !wready |=> w == w_prev)
      else report_bus($sformatf("** Error at %0t: w expected %h, got %h",
                                $time, $sampled(w_prev), $sampled(w)));

   assert property (@(posedge clk) disable iff (!reset_n) awvalid && awready |-> aw_expected)
      else report_bus($sformatf("at %0t AW accepted with none expected", $time));

   assert property (@(posedge clk) disable iff (!reset_n) awvalid && awready |-> aw == exp_aw)
      else report_bus($sformatf("** Error at %0t: aw expected %h, got %h",
                                $time, $sampled(exp_aw), $sampled(aw)));

   assert property (@(posedge clk) disable iff (!reset_n) wvalid && wready |-> w_expected)
      else report_bus($sformatf("at %0t W beat accepted with none expected", $time));

   assert property (@(posedge clk) disable iff (!reset_n)
         wvalid && wready |-> w.data == exp_data)
      else report_bus($sformatf("** Error at %0t: w.data expected %h, got %h",
                                $time, $sampled(exp_data), $sampled(w.data)));

   assert property (@(posedge clk) disable iff (!reset_n)
         wvalid && wready |-> w.last == exp_last)
      else report_bus($sformatf("** Error at %0t: w.last expected %b, got %b",
                                $time, $sampled(exp_last), $sampled(w.last)));

   assert property (@(posedge clk) disable iff (!reset_n) wvalid && wready |-> w.strb == 4'hf)
      else report_bus($sformatf("** Error at %0t: w.strb expected f, got %h",
                                $time, $sampled(w.strb)));

   assert property (@(posedge clk) disable iff (!reset_n) wvalid |-> aw_seen > bursts_done)
      else report_bus($sformatf("at %0t W data sent before its AW", $time));

   assert property (@(posedge clk) disable iff (!reset_n) wr_done |-> !expect_err)
      else report_bus($sformatf("at %0t wr_done pulsed after an error response", $time));

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual == expected) else begin
         check_errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_cond(input string what, input bit ok);
      assert (ok) else begin
         check_errors++;
         $display("at %0t check failed: %s", $time, what);
      end
   endtask

   task automatic csr_write(input logic [2:0] addr, input logic [31:0] data);
      @(posedge clk);
      csr_wr    <= 1'b1;
      csr_addr  <= addr;
      csr_wdata <= data;
      @(posedge clk);
      csr_wr <= 1'b0;
   endtask

   task automatic csr_read(input logic [2:0] addr, output logic [31:0] data);
      @(posedge clk);
      csr_rd   <= 1'b1;
      csr_addr <= addr;
      @(posedge clk);
      csr_rd <= 1'b0;
      @(posedge clk);
      check_cond("csr_rvalid one cycle after the read strobe", csr_rvalid);
      data = csr_rdata;
   endtask

   task automatic read_status(output dma_types_pkg::t_status st);
      logic [31:0] val;
      csr_read(dma_types_pkg::REG_STATUS, val);
      st = dma_types_pkg::t_status'(val[$bits(dma_types_pkg::t_status)-1:0]);
   endtask

   // one AW per 16 beats at 64-byte steps with the remainder in the last
   task automatic expect_bursts(input logic [31:0] base, input int length,
                                input dma_types_pkg::t_mode mode);
      int              n;
      axi_wr_pkg::t_aw a;
      n = (length + 15) / 16;
      for (int i = 0; i < n; i++) begin
         a.addr  = base + 32'(64 * i);
         a.len   = (i == n - 1) ? 4'(length - 16 * (n - 1) - 1) : 4'd15;
         a.size  = 3'd2;
         a.burst = (mode == dma_types_pkg::ddr_to_host) ? axi_wr_pkg::BURST_WRAP :
                   axi_wr_pkg::BURST_INCR;
         exp_aw_q.push_back(a);
      end
   endtask

   task automatic push_beats(input int count);
      dma_types_pkg::t_beat beat;
      int                   i;
      i = 0;
      while (i < count) begin
         @(posedge clk);
         if (beats_pushed - beats_accepted < AHEAD_LIMIT) begin
            beat.data            = $urandom();
            beat.burst_last      = (i % 16 == 15) || (i == count - 1);
            beat.packet_complete = (i == count - 1);
            beat_push <= 1'b1;
            push_data <= beat;
            exp_data_q.push_back(beat.data);
            exp_last_q.push_back(beat.burst_last);
            beats_pushed++;
            i++;
         end else begin
            beat_push <= 1'b0;
         end
      end
      @(posedge clk);
      beat_push <= 1'b0;
   endtask

   task automatic run_transfer(input logic [31:0] base, input int length,
                               input dma_types_pkg::t_mode mode);
      expect_bursts(base, length, mode);
      csr_write(dma_types_pkg::REG_DEST_ADDR, base);
      csr_write(dma_types_pkg::REG_LENGTH, 32'(length));
      csr_write(dma_types_pkg::REG_CONTROL, {28'd0, mode, 2'b01});
      push_beats(length);
   endtask

   task automatic wait_done();
      do @(posedge clk); while (!wr_done);
   endtask

   task automatic check_transfer(input int length, input int transfers);
      logic [31:0]            val;
      dma_types_pkg::t_status st;
      check_cond("every expected AW was issued", exp_aw_q.size() == 0);
      check_cond("every pushed beat was written", exp_data_q.size() == 0);
      check_value("received beats", 32'(beats_pushed), 32'(rx_data_q.size()));
      csr_read(dma_types_pkg::REG_VALID_CNT, val);
      check_value("valid_cnt", 32'(length), val);
      csr_read(dma_types_pkg::REG_CLK_CNT, val);
      check_cond("clk_cnt covers at least the length", val >= 32'(length));
      read_status(st);
      check_value("status.busy", 32'd0, 32'(st.busy));
      check_value("wr_done pulses", 32'(transfers), 32'(done_count));
   endtask

   initial begin
      dma_types_pkg::t_status st;
      void'($urandom(32'h12ca));
      reset_n    = 1'b0;
      csr_wr     = 1'b0;
      csr_rd     = 1'b0;
      csr_addr   = '0;
      csr_wdata  = '0;
      beat_push  = 1'b0;
      push_data  = '0;
      resp_code  = axi_wr_pkg::OKAY;
      stall_en   = 1'b0;
      expect_err = 1'b0;
      repeat (10) @(posedge clk);
      reset_n <= 1'b1;

      read_status(st);
      check_value("status flags after reset", 32'd0,
                  32'({st.busy, st.stopped_on_error, st.wr_rsp_err}));

      run_transfer(32'h0000_1000, 5, dma_types_pkg::host_to_ddr);
      wait_done();
      check_transfer(5, 1);

      // two full bursts and a partial one
      run_transfer(32'h0000_2000, 40, dma_types_pkg::ddr_to_ddr);
      wait_done();
      check_transfer(40, 2);

      stall_en <= 1'b1;
      run_transfer(32'h0000_8000, 40, dma_types_pkg::host_to_ddr);
      wait_done();
      check_transfer(40, 3);

      // error response parks the engine
      resp_code  <= axi_wr_pkg::SLVERR;
      expect_err <= 1'b1;
      run_transfer(32'h0000_3000, 5, dma_types_pkg::host_to_ddr);
      do @(posedge clk); while (!(bvalid && bready));
      read_status(st);
      check_value("status.stopped_on_error", 32'd1, 32'(st.stopped_on_error));
      check_value("status.wr_rsp_err", 32'd1, 32'(st.wr_rsp_err));
      check_value("status.busy", 32'd0, 32'(st.busy));
      check_value("wr_done pulses", 32'd3, 32'(done_count));

      csr_write(dma_types_pkg::REG_CONTROL, {28'd0, dma_types_pkg::ddr_to_host, 2'b10});
      resp_code  <= axi_wr_pkg::OKAY;
      expect_err <= 1'b0;
      read_status(st);
      check_value("status.stopped_on_error", 32'd0, 32'(st.stopped_on_error));
      check_value("status.wr_rsp_err", 32'd0, 32'(st.wr_rsp_err));

      run_transfer(32'h0000_4000, 8, dma_types_pkg::ddr_to_host);
      wait_done();
      check_transfer(8, 4);

      repeat (4) @(posedge clk);
      $display("checks done: %0d value errors, %0d protocol errors",
               check_errors, protocol_errors);
      if (check_errors == 0 && protocol_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dma_wr.f ====
verilog/dma_types_pkg.sv
verilog/axi_wr_pkg.sv
verilog/dma_wr_csr.sv
verilog/data_fifo.sv
verilog/write_dest_fsm.sv
verilog/dma_wr_top.sv
tests/tb_dma_wr.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds tb_dma_wr with Verilator and runs it; nonzero exit on any failure
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dma_wr -Mdir "$OBJ" -o sim_tb_dma_wr -f dma_wr.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/sim_tb_dma_wr" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
   exit 1
fi
exit 0
